// ==== rtl/vic_pkg.sv ====
package vic_pkg;

   ////////////////////
   // Sizes
   ////////////////////

   localparam int NUM_SRC   = 8;
   localparam int ID_W      = 3;   // Enough bits for NUM_SRC
   localparam int VEC_SHIFT = 4;   // 16 byte vector slots

   typedef logic [31:0]        pc_t;
   typedef logic [3:0]         ccodes_t;
   typedef logic [ID_W-1:0]    irq_id_t;
   typedef logic [NUM_SRC-1:0] irq_mask_t;
   typedef logic [7:0]         holdoff_t;
   typedef logic [7:0]         apb_addr_t;

   ////////////////////
   // Register map
   ////////////////////

   localparam apb_addr_t REG_ENABLE  = 8'h00;
   localparam apb_addr_t REG_PENDING = 8'h04;   // W1C
   localparam apb_addr_t REG_VBASE   = 8'h08;
   localparam apb_addr_t REG_HOLDOFF = 8'h0C;
   localparam apb_addr_t REG_STATUS  = 8'h10;   // Read only

   typedef enum logic [1:0] {
      IDLE,
      WAIT_SLOT,   // Request seen, execute stage holds a bubble
      IN_ISR,
      HOLD
   } vic_state_t;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      apb_addr_t   paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   // Execute stage context
   typedef struct packed {
      pc_t     pc;
      ccodes_t cc;
   } cpu_ctx_t;

   typedef struct packed {
      logic    valid;
      pc_t     addr;
      logic    cc_load;   // Restore codes along with the jump
      ccodes_t cc;
   } redirect_t;

endpackage

// ==== rtl/vic_apb_regs.sv ====
module vic_apb_regs (
   input  logic               clk,
   input  logic               rst,
   input  vic_pkg::apb_req_t  i_apb,
   output vic_pkg::apb_rsp_t  o_apb,
   input  vic_pkg::irq_mask_t i_irq_src,
   input  logic               i_ack,
   input  vic_pkg::irq_id_t   i_ack_id,
   input  logic               i_in_isr,
   input  vic_pkg::irq_id_t   i_active_id,
   output vic_pkg::irq_mask_t o_pending,
   output vic_pkg::irq_mask_t o_enable,
   output vic_pkg::pc_t       o_vbase,
   output vic_pkg::holdoff_t  o_holdoff
);
   import vic_pkg::*;

   irq_mask_t   src_q;
   irq_mask_t   src_rise;
   irq_mask_t   sw_clr;
   irq_mask_t   ack_clr;
   irq_mask_t   enable_q;
   irq_mask_t   pending_q;
   pc_t         vbase_q;
   holdoff_t    holdoff_q;
   logic        access;
   logic        addr_ok;
   logic        status_wr;
   logic        wr_en;
   logic [31:0] rdata;

   ////////////////////
   // APB decode
   ////////////////////

   assign access    = i_apb.psel & i_apb.penable;   // Access phase, never stretched
   assign status_wr = i_apb.pwrite & (i_apb.paddr == REG_STATUS);
   assign wr_en     = access & i_apb.pwrite & addr_ok & ~status_wr;

   always_comb
   begin
      addr_ok = 1'b1;
      rdata   = '0;
      case (i_apb.paddr)
         REG_ENABLE:  rdata = 32'(enable_q);
         REG_PENDING: rdata = 32'(pending_q);
         REG_VBASE:   rdata = vbase_q;
         REG_HOLDOFF: rdata = 32'(holdoff_q);
         REG_STATUS:  rdata = {25'd0, i_active_id, 3'd0, i_in_isr};
         default:     addr_ok = 1'b0;
      endcase
   end

   assign o_apb.prdata  = rdata;
   assign o_apb.pready  = access;
   assign o_apb.pslverr = access & (~addr_ok | status_wr);

   // Config registers
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         enable_q  <= '0;
         vbase_q   <= '0;
         holdoff_q <= '0;
      end
      else if (wr_en)
      begin
         case (i_apb.paddr)
            REG_ENABLE:  enable_q  <= irq_mask_t'(i_apb.pwdata);
            REG_VBASE:   vbase_q   <= {i_apb.pwdata[31:7], 7'd0};   // 8 slots of 16 bytes
            REG_HOLDOFF: holdoff_q <= holdoff_t'(i_apb.pwdata);
            default:     ;
         endcase
      end
   end

   ////////////////////
   // Pending bits
   ////////////////////

   assign src_rise = i_irq_src & ~src_q;

   always_comb
   begin
      sw_clr  = '0;
      ack_clr = '0;
      if (wr_en && (i_apb.paddr == REG_PENDING))
         sw_clr = irq_mask_t'(i_apb.pwdata);
      if (i_ack)
         ack_clr[i_ack_id] = 1'b1;
   end

   // New edge wins over a clear in the same cycle
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         src_q     <= '0;
         pending_q <= '0;
      end
      else
      begin
         src_q     <= i_irq_src;
         pending_q <= (pending_q & ~(sw_clr | ack_clr)) | src_rise;
      end
   end

   assign o_pending = pending_q;
   assign o_enable  = enable_q;
   assign o_vbase   = vbase_q;
   assign o_holdoff = holdoff_q;

endmodule

// ==== rtl/vic_priority.sv ====
module vic_priority (
   input  vic_pkg::irq_mask_t i_pending,
   input  vic_pkg::irq_mask_t i_enable,
   input  vic_pkg::pc_t       i_vbase,
   output logic               o_req,
   output vic_pkg::irq_id_t   o_id,
   output vic_pkg::pc_t       o_vec_addr
);
   import vic_pkg::*;

   irq_mask_t masked;

   assign masked = i_pending & i_enable;

   // Scan from the top so the lowest index is written last
   always_comb
   begin
      o_req = 1'b0;
      o_id  = '0;
      for (int i = NUM_SRC - 1; i >= 0; i--)
      begin
         if (masked[i])
         begin
            o_req = 1'b1;
            o_id  = irq_id_t'(i);
         end
      end
   end

   assign o_vec_addr = i_vbase + (pc_t'(o_id) << VEC_SHIFT);   // Base plus id * 16

endmodule

// ==== rtl/vic_holdoff_timer.sv ====
module vic_holdoff_timer (
   input  logic              clk,
   input  logic              rst,
   input  logic              i_start,
   input  vic_pkg::holdoff_t i_count,
   output logic              o_busy
);
   import vic_pkg::*;

   holdoff_t cnt_q;

   always_ff @(posedge clk)
   begin
      if (rst)
         cnt_q <= '0;
      else if (i_start)
         cnt_q <= i_count;   // Reload, even while running
      else if (cnt_q != '0)
         cnt_q <= cnt_q - 1'b1;
   end

   assign o_busy = (cnt_q != '0);

endmodule

// ==== rtl/vic_ctrl.sv ====
module vic_ctrl (
   input  logic              clk,
   input  logic              rst,
   input  logic              i_req,
   input  vic_pkg::irq_id_t  i_id,
   input  vic_pkg::pc_t      i_vec_addr,
   input  vic_pkg::cpu_ctx_t i_ctx,
   input  logic              i_not_flush,
   input  logic              i_reti,
   input  logic              i_holdoff_busy,
   output logic              o_ack,
   output vic_pkg::irq_id_t  o_ack_id,
   output logic              o_holdoff_start,
   output logic              o_in_isr,
   output vic_pkg::irq_id_t  o_active_id,
   output vic_pkg::redirect_t o_redirect
);
   import vic_pkg::*;

   vic_state_t state;
   vic_state_t state_nxt;
   cpu_ctx_t   saved_q;
   irq_id_t    active_q;
   logic       hold_done;
   logic       take_entry;
   logic       tail_chain;
   logic       plain_ret;
   logic       rdr_valid;
   logic       rdr_cc_load;
   pc_t        rdr_addr;
   ccodes_t    rdr_cc;

   ////////////////////
   // Event decode
   ////////////////////

   // Timer idle makes HOLD behave like IDLE
   assign hold_done = (state == HOLD) & ~i_holdoff_busy;

   assign take_entry = i_req & i_not_flush &
                       ((state == IDLE) | (state == WAIT_SLOT) | hold_done);
   assign tail_chain = (state == IN_ISR) & i_reti & i_req;
   assign plain_ret  = (state == IN_ISR) & i_reti & ~i_req;

   always_comb
   begin
      state_nxt = state;
      case (state)
         IDLE, WAIT_SLOT:
         begin
            if (take_entry)
               state_nxt = IN_ISR;
            else if (i_req)
               state_nxt = WAIT_SLOT;   // Bubble in execute
            else
               state_nxt = IDLE;        // Request cleared by software
         end
         IN_ISR:
         begin
            if (plain_ret)
               state_nxt = HOLD;
         end
         HOLD:
         begin
            if (take_entry)
               state_nxt = IN_ISR;
            else if (hold_done)
               state_nxt = i_req ? WAIT_SLOT : IDLE;
         end
         default: state_nxt = IDLE;
      endcase
   end

   ////////////////////
   // Registers
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state       <= IDLE;
         rdr_valid   <= 1'b0;
         rdr_cc_load <= 1'b0;
         active_q    <= '0;
      end
      else
      begin
         state       <= state_nxt;
         rdr_valid   <= take_entry | tail_chain | plain_ret;   // One cycle pulse
         rdr_cc_load <= plain_ret;
         if (take_entry | tail_chain)
            active_q <= i_id;
      end
   end

   // Context and redirect target
   always_ff @(posedge clk)
   begin
      if (take_entry)
         saved_q <= i_ctx;    // Tail chain keeps the first context
      rdr_addr <= plain_ret ? saved_q.pc : i_vec_addr;
      rdr_cc   <= saved_q.cc;
   end

   // Pending clears at the same edge the entry is taken
   assign o_ack           = take_entry | tail_chain;
   assign o_ack_id        = i_id;
   assign o_holdoff_start = plain_ret;
   assign o_in_isr        = (state == IN_ISR);
   assign o_active_id     = active_q;

   assign o_redirect.valid   = rdr_valid;
   assign o_redirect.addr    = rdr_addr;
   assign o_redirect.cc_load = rdr_cc_load;
   assign o_redirect.cc      = rdr_cc;

endmodule

// ==== rtl/vic_top.sv ====
module vic_top (
   input  logic               clk,
   input  logic               rst,
   input  vic_pkg::apb_req_t  i_apb,
   output vic_pkg::apb_rsp_t  o_apb,
   input  vic_pkg::irq_mask_t i_irq_src,
   input  vic_pkg::cpu_ctx_t  i_ctx,
   input  logic               i_not_flush,
   input  logic               i_reti,
   output vic_pkg::redirect_t o_redirect
);
   import vic_pkg::*;

   irq_mask_t pending;
   irq_mask_t enable;
   pc_t       vbase;
   holdoff_t  holdoff;
   logic      req;
   irq_id_t   win_id;
   pc_t       vec_addr;
   logic      ack;
   irq_id_t   ack_id;
   logic      in_isr;
   irq_id_t   active_id;
   logic      hold_start;
   logic      hold_busy;

   vic_apb_regs u_regs (
      .clk         (clk),
      .rst         (rst),
      .i_apb       (i_apb),
      .o_apb       (o_apb),
      .i_irq_src   (i_irq_src),
      .i_ack       (ack),
      .i_ack_id    (ack_id),
      .i_in_isr    (in_isr),
      .i_active_id (active_id),
      .o_pending   (pending),
      .o_enable    (enable),
      .o_vbase     (vbase),
      .o_holdoff   (holdoff)
   );

   vic_priority u_prio (
      .i_pending  (pending),
      .i_enable   (enable),
      .i_vbase    (vbase),
      .o_req      (req),
      .o_id       (win_id),
      .o_vec_addr (vec_addr)
   );

   vic_holdoff_timer u_timer (
      .clk     (clk),
      .rst     (rst),
      .i_start (hold_start),
      .i_count (holdoff),
      .o_busy  (hold_busy)
   );

   vic_ctrl u_ctrl (
      .clk             (clk),
      .rst             (rst),
      .i_req           (req),
      .i_id            (win_id),
      .i_vec_addr      (vec_addr),
      .i_ctx           (i_ctx),
      .i_not_flush     (i_not_flush),
      .i_reti          (i_reti),
      .i_holdoff_busy  (hold_busy),
      .o_ack           (ack),
      .o_ack_id        (ack_id),
      .o_holdoff_start (hold_start),
      .o_in_isr        (in_isr),
      .o_active_id     (active_id),
      .o_redirect      (o_redirect)
   );

endmodule

// ==== bench/vic_assert.sv ====
module vic_assert (
   input  logic               clk,
   input  logic               rst,
   input  vic_pkg::apb_req_t  i_apb,
   input  vic_pkg::apb_rsp_t  o_apb,
   input  vic_pkg::redirect_t o_redirect
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0;   // Polled by the testbench

   ////////////////////
   // Redirect rules
   ////////////////////

   a_redirect_pulse: assert property (@(posedge clk) disable iff (rst)
      o_redirect.valid |=> !o_redirect.valid)
   else
   begin
      fail_cnt++;
      $error("Redirect valid high for two cycles in a row");
   end

   a_cc_load_valid: assert property (@(posedge clk) disable iff (rst)
      o_redirect.cc_load |-> o_redirect.valid)
   else
   begin
      fail_cnt++;
      $error("Condition code load without a valid redirect");
   end

   ////////////////////
   // APB rules
   ////////////////////

   a_pready_access: assert property (@(posedge clk) disable iff (rst)
      o_apb.pready |-> (i_apb.psel && i_apb.penable))
   else
   begin
      fail_cnt++;
      $error("PREADY outside the access phase");
   end

   a_pslverr_ready: assert property (@(posedge clk) disable iff (rst)
      o_apb.pslverr |-> o_apb.pready)
   else
   begin
      fail_cnt++;
      $error("PSLVERR without PREADY");
   end

endmodule

bind vic_top vic_assert u_assert (
   .clk        (clk),
   .rst        (rst),
   .i_apb      (i_apb),
   .o_apb      (o_apb),
   .o_redirect (o_redirect)
);

// ==== bench/vic_tb.sv ====
module vic_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import vic_pkg::*;

   localparam int  WAIT_LIMIT = 60;
   localparam pc_t VBASE      = 32'h0000_1000;

   logic        clk;
   logic        rst;
   apb_req_t    apb_req;
   apb_rsp_t    apb_rsp;
   irq_mask_t   irq_src;
   cpu_ctx_t    ctx;
   logic        not_flush;
   logic        reti;
   redirect_t   redirect;
   int          seed = 38;
   int unsigned cycle = 0;
   int unsigned redirect_cycle;   // Cycle of the last seen redirect
   redirect_t   rd;

   vic_top UUT (
      .clk         (clk),
      .rst         (rst),
      .i_apb       (apb_req),
      .o_apb       (apb_rsp),
      .i_irq_src   (irq_src),
      .i_ctx       (ctx),
      .i_not_flush (not_flush),
      .i_reti      (reti),
      .o_redirect  (redirect)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk)
      cycle <= cycle + 1;

   always @(negedge clk)
   begin
      if (UUT.u_assert.fail_cnt != 0)
         stop_on_error("A bound protocol assertion failed");
   end

   ////////////////////
   // Helpers
   ////////////////////

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
         stop_on_error($sformatf("MISMATCH at %0t ns: %s = %h, expected %h",
                                 $time, name, got, exp));
   endtask

   task automatic after_edge();
      @(posedge clk);
      #1;
   endtask

   task automatic apb_xfer(input logic wr, input apb_addr_t addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      int n;
      after_edge();
      apb_req.psel    = 1'b1;   // Setup phase
      apb_req.penable = 1'b0;
      apb_req.pwrite  = wr;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      after_edge();
      apb_req.penable = 1'b1;
      n = 0;
      @(negedge clk);
      while (!apb_rsp.pready)
      begin
         n++;
         if (n > WAIT_LIMIT)
            stop_on_error("APB access got no PREADY");
         @(negedge clk);
      end
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      after_edge();
      apb_req = '0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, input logic exp_err);
      logic [31:0] rdata;
      logic        err;
      apb_xfer(1'b1, addr, data, rdata, err);
      check_eq($sformatf("pslverr (write %h)", addr), err, exp_err);
   endtask

   task automatic apb_read_check(input apb_addr_t addr, input logic [31:0] exp);
      logic [31:0] rdata;
      logic        err;
      apb_xfer(1'b0, addr, 32'd0, rdata, err);
      check_eq($sformatf("pslverr (read %h)", addr), err, 1'b0);
      check_eq($sformatf("prdata (read %h)", addr), rdata, exp);
   endtask

   task automatic new_ctx();
      ctx.pc = $random(seed);
      ctx.cc = ccodes_t'($random(seed));
   endtask

   task automatic pulse_src(input irq_mask_t m);
      after_edge();
      irq_src = m;
      after_edge();
      irq_src = '0;
   endtask

   task automatic pulse_reti();
      after_edge();
      reti = 1'b1;
      after_edge();
      reti = 1'b0;
   endtask

   // CPU fetch side, takes the next redirect pulse
   task automatic wait_redirect();
      int n;
      n = 0;
      @(negedge clk);
      while (!redirect.valid)
      begin
         n++;
         if (n > WAIT_LIMIT)
            stop_on_error($sformatf("Timed out at %0t ns waiting for a redirect", $time));
         @(negedge clk);
      end
      rd             = redirect;
      redirect_cycle = cycle;
   endtask

   task automatic expect_quiet(input int cycles);
      repeat (cycles)
      begin
         @(negedge clk);
         assert (!redirect.valid)
         else
            stop_on_error($sformatf("Unexpected redirect at %0t ns to %h", $time, redirect.addr));
      end
   endtask

   task automatic check_entry(input irq_id_t id);
      wait_redirect();
      check_eq("o_redirect.addr", rd.addr, VBASE + 32'(id) * 16);   // 16 byte slots
      check_eq("o_redirect.cc_load", rd.cc_load, 1'b0);
   endtask

   task automatic check_restore(input cpu_ctx_t exp);
      wait_redirect();
      check_eq("o_redirect.addr", rd.addr, exp.pc);
      check_eq("o_redirect.cc_load", rd.cc_load, 1'b1);
      check_eq("o_redirect.cc", rd.cc, exp.cc);
   endtask

   ////////////////////
   // Directed tests
   ////////////////////

   task automatic test_registers();
      logic [31:0] rdata;
      logic        err;
      apb_write(REG_ENABLE, 32'h0000_00A5, 1'b0);
      apb_read_check(REG_ENABLE, 32'h0000_00A5);
      apb_write(REG_VBASE, 32'h1234_56FF, 1'b0);
      apb_read_check(REG_VBASE, 32'h1234_5680);   // Low 7 bits read as zero
      apb_write(REG_HOLDOFF, 32'h0000_003C, 1'b0);
      apb_read_check(REG_HOLDOFF, 32'h0000_003C);
      apb_xfer(1'b0, 8'h20, 32'd0, rdata, err);
      check_eq("pslverr (read 20)", err, 1'b1);
      apb_write(REG_STATUS, 32'h1, 1'b1);
      // Source 7 stays masked until the masking test
      apb_write(REG_ENABLE, 32'h0000_007F, 1'b0);
      apb_write(REG_VBASE, VBASE, 1'b0);
      apb_write(REG_HOLDOFF, 32'd0, 1'b0);
   endtask

   task automatic test_entry_return();
      cpu_ctx_t orig;
      after_edge();
      new_ctx();
      orig = ctx;
      pulse_src(8'h08);
      check_entry(3);
      apb_read_check(REG_PENDING, 32'h0);
      apb_read_check(REG_STATUS, 32'h31);   // in_isr, id 3
      after_edge();
      new_ctx();                            // ISR body runs elsewhere
      pulse_reti();
      check_restore(orig);
   endtask

   task automatic test_tail_chain();
      cpu_ctx_t orig;
      after_edge();
      new_ctx();
      orig = ctx;
      pulse_src(8'h24);
      check_entry(2);
      after_edge();
      new_ctx();
      pulse_reti();
      check_entry(5);   // Chained, context kept
      pulse_reti();
      check_restore(orig);
   endtask

   task automatic test_flush();
      cpu_ctx_t orig;
      after_edge();
      not_flush = 1'b0;
      new_ctx();
      pulse_src(8'h02);
      expect_quiet(8);
      after_edge();
      not_flush = 1'b1;
      new_ctx();
      orig = ctx;
      check_entry(1);
      pulse_reti();
      check_restore(orig);
   endtask

   task automatic test_masking();
      cpu_ctx_t orig;
      after_edge();
      new_ctx();
      orig = ctx;
      pulse_src(8'h80);
      expect_quiet(6);
      apb_read_check(REG_PENDING, 32'h80);
      apb_write(REG_ENABLE, 32'h0000_00FF, 1'b0);
      check_entry(7);
      pulse_reti();
      check_restore(orig);
   endtask

   task automatic test_holdoff();
      cpu_ctx_t    orig;
      int unsigned ret_cycle;
      apb_write(REG_HOLDOFF, 32'd10, 1'b0);
      after_edge();
      new_ctx();
      orig = ctx;
      pulse_src(8'h10);
      check_entry(4);
      pulse_reti();
      check_restore(orig);
      ret_cycle = redirect_cycle;
      pulse_src(8'h10);
      check_entry(4);
      assert (redirect_cycle - ret_cycle > 10)
      else
         stop_on_error($sformatf("Entry came %0d cycles after return with hold-off 10",
                                 redirect_cycle - ret_cycle));
      pulse_reti();
      check_restore(orig);
   endtask

   initial
   begin
      rst       = 1'b1;
      apb_req   = '0;
      irq_src   = '0;
      ctx       = '0;
      not_flush = 1'b1;
      reti      = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;

      test_registers();
      test_entry_return();
      test_tail_chain();
      test_flush();
      test_masking();
      test_holdoff();

      after_edge();
      if (UUT.u_assert.fail_cnt != 0)
         stop_on_error("Bound protocol assertions failed during the run");
      else
      begin
         $display("TEST RESULT: PASS");
         $finish;
      end
   end

endmodule

// ==== flist.f ====
rtl/vic_pkg.sv
rtl/vic_apb_regs.sv
rtl/vic_priority.sv
rtl/vic_holdoff_timer.sv
rtl/vic_ctrl.sv
rtl/vic_top.sv
bench/vic_assert.sv
bench/vic_tb.sv
